// ==== rtl/udp_echo_pkg.sv ====
// UDP echo core package with field widths, header and payload beat types, default config
package udp_echo_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [63:0] payload_data_t;
    typedef logic [7:0]  payload_keep_t;
    typedef logic [7:0]  led_t;

    // Decoded UDP header, used for both the received and the reply direction
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_hdr_t;

    // One 64-bit payload word with its sideband
    typedef struct packed {
        payload_data_t data;
        payload_keep_t keep;
        logic          last;
        // Error flag from upstream, carried through untouched
        logic          user;
    } payload_beat_t;

    // Default port that gets echoed
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // 192.168.1.128
    localparam ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

endpackage

// ==== rtl/udp_port_filter.sv ====
// Per-frame port filter, forwards header and payload of echo frames and drops the rest
`timescale 1ns/1ps

module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = udp_echo_pkg::DEFAULT_ECHO_PORT
) (
    input  logic                        clk,
    input  logic                        rst,

    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    output udp_echo_pkg::udp_hdr_t      echo_hdr,
    output logic                        echo_hdr_valid,
    input  logic                        echo_hdr_ready,
    output udp_echo_pkg::payload_beat_t fifo_in,
    output logic                        fifo_in_valid,
    input  logic                        fifo_in_ready
);

    typedef enum logic [1:0] {
        IDLE,
        ECHO,
        DROP
    } filter_state_t;

    filter_state_t state;
    filter_state_t state_next;

    logic hdr_match;
    logic hdr_xfer;
    logic last_xfer;

    // Port decision is only taken while a header waits in IDLE
    assign hdr_match = (rx_hdr.dest_port == ECHO_PORT);

    // Header side, echo transfer coincides with the rx transfer
    assign echo_hdr       = rx_hdr;
    assign echo_hdr_valid = (state == IDLE) && rx_hdr_valid && hdr_match;
    assign rx_hdr_ready   = (state == IDLE) && (!hdr_match || echo_hdr_ready);

    // Payload passes straight through while echoing
    assign fifo_in       = rx_payload;
    assign fifo_in_valid = (state == ECHO) && rx_payload_valid;

    always_comb begin
        case (state)
            ECHO:    rx_payload_ready = fifo_in_ready;
            DROP:    rx_payload_ready = 1'b1;
            default: rx_payload_ready = 1'b0;
        endcase
    end

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload.last;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_xfer) begin
                    state_next = hdr_match ? ECHO : DROP;
                end
            end
            ECHO, DROP: begin
                // Frame ends on its last beat, echoed or swallowed
                if (last_xfer) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== rtl/udp_reply_header.sv ====
// Reply header register, rewrites addresses and ports and holds the result for tx
`timescale 1ns/1ps

module udp_reply_header #(
    parameter udp_echo_pkg::ip_addr_t LOCAL_IP = udp_echo_pkg::DEFAULT_LOCAL_IP
) (
    input  logic                   clk,
    input  logic                   rst,

    input  udp_echo_pkg::udp_hdr_t echo_hdr,
    input  logic                   echo_hdr_valid,
    output logic                   echo_hdr_ready,

    output udp_echo_pkg::udp_hdr_t tx_hdr,
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready
);

    udp_echo_pkg::udp_hdr_t reply_hdr;
    logic                   full;

    // Room when empty, or when the held header leaves this cycle
    assign echo_hdr_ready = !full || tx_hdr_ready;

    assign tx_hdr       = reply_hdr;
    assign tx_hdr_valid = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (echo_hdr_valid && echo_hdr_ready) begin
            full <= 1'b1;
        end else if (tx_hdr_ready) begin
            full <= 1'b0;
        end
    end

    // Send back to the sender from the local address
    always_ff @(posedge clk) begin
        if (echo_hdr_valid && echo_hdr_ready) begin
            reply_hdr.source_ip   <= LOCAL_IP;
            reply_hdr.dest_ip     <= echo_hdr.source_ip;
            reply_hdr.source_port <= echo_hdr.dest_port;
            reply_hdr.dest_port   <= echo_hdr.source_port;
            reply_hdr.length      <= echo_hdr.length;
        end
    end

endmodule

// ==== rtl/udp_payload_fifo.sv ====
// Circular-buffer FIFO for payload beats with valid/ready on both sides
`timescale 1ns/1ps

module udp_payload_fifo #(
    // Must be a power of two
    parameter int FIFO_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst,

    input  udp_echo_pkg::payload_beat_t fifo_in,
    input  logic                        fifo_in_valid,
    output logic                        fifo_in_ready,

    output udp_echo_pkg::payload_beat_t tx_payload,
    output logic                        tx_payload_valid,
    input  logic                        tx_payload_ready
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    udp_echo_pkg::payload_beat_t mem [FIFO_DEPTH];

    // Extra MSB tells full from empty when the addresses meet
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic empty;
    logic full;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign fifo_in_ready    = !full;
    assign tx_payload_valid = !empty;

    assign wr_en = fifo_in_valid && fifo_in_ready;
    assign rd_en = tx_payload_valid && tx_payload_ready;

    // Head of the queue, visible from the cycle after its write
    assign tx_payload = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= fifo_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== rtl/payload_led_latch.sv ====
// LED latch showing the low byte of the first outgoing payload beat of each frame
`timescale 1ns/1ps

module payload_led_latch (
    input  logic                        clk,
    input  logic                        rst,

    input  udp_echo_pkg::payload_beat_t tx_payload,
    input  logic                        tx_payload_valid,
    input  logic                        tx_payload_ready,

    output udp_echo_pkg::led_t          led
);

    logic xfer;
    // Set between the first and the last beat of a frame
    logic in_frame;

    assign xfer = tx_payload_valid && tx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (xfer) begin
            in_frame <= !tx_payload.last;
            if (!in_frame) begin
                led <= tx_payload.data[7:0];
            end
        end
    end

endmodule

// ==== rtl/udp_echo_top.sv ====
// UDP echo core top level, joining port filter, reply header, payload FIFO and LED latch
`timescale 1ns/1ps

module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT  = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP   = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter int                      FIFO_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst,

    // Received UDP header and payload
    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,

    // Reply header and payload
    output udp_echo_pkg::udp_hdr_t      tx_hdr,
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t tx_payload,
    output logic                        tx_payload_valid,
    input  logic                        tx_payload_ready,

    output udp_echo_pkg::led_t          led
);

    // Original header of a matching frame
    udp_echo_pkg::udp_hdr_t      echo_hdr;
    logic                        echo_hdr_valid;
    logic                        echo_hdr_ready;

    // Payload of matching frames on its way into the FIFO
    udp_echo_pkg::payload_beat_t fifo_in;
    logic                        fifo_in_valid;
    logic                        fifo_in_ready;

    udp_port_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) u_port_filter (
        .clk             (clk),
        .rst             (rst),
        .rx_hdr          (rx_hdr),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_payload      (rx_payload),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .echo_hdr        (echo_hdr),
        .echo_hdr_valid  (echo_hdr_valid),
        .echo_hdr_ready  (echo_hdr_ready),
        .fifo_in         (fifo_in),
        .fifo_in_valid   (fifo_in_valid),
        .fifo_in_ready   (fifo_in_ready)
    );

    udp_reply_header #(
        .LOCAL_IP(LOCAL_IP)
    ) u_reply_header (
        .clk           (clk),
        .rst           (rst),
        .echo_hdr      (echo_hdr),
        .echo_hdr_valid(echo_hdr_valid),
        .echo_hdr_ready(echo_hdr_ready),
        .tx_hdr        (tx_hdr),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr_ready  (tx_hdr_ready)
    );

    udp_payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_payload_fifo (
        .clk             (clk),
        .rst             (rst),
        .fifo_in         (fifo_in),
        .fifo_in_valid   (fifo_in_valid),
        .fifo_in_ready   (fifo_in_ready),
        .tx_payload      (tx_payload),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready)
    );

    payload_led_latch u_led_latch (
        .clk             (clk),
        .rst             (rst),
        .tx_payload      (tx_payload),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .led             (led)
    );

endmodule

// ==== dv/udp_echo_assertions.sv ====
// Stream handshake and LED reset assertions, bound to the UDP echo top level
`timescale 1ns/1ps

module udp_echo_assertions (
    input logic                        clk,
    input logic                        rst,
    input logic                        rx_hdr_ready,
    input logic                        rx_payload_ready,
    input udp_echo_pkg::udp_hdr_t      tx_hdr,
    input logic                        tx_hdr_valid,
    input logic                        tx_hdr_ready,
    input udp_echo_pkg::payload_beat_t tx_payload,
    input logic                        tx_payload_valid,
    input logic                        tx_payload_ready,
    input udp_echo_pkg::led_t          led
);

    // A stalled header keeps its valid and its contents
    tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else $error("tx_hdr changed while stalled");

    tx_payload_hold: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload))
        else $error("tx_payload changed while stalled");

    // Header and payload are accepted in different filter states
    rx_ready_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(rx_hdr_ready && rx_payload_ready))
        else $error("rx_hdr_ready and rx_payload_ready high together");

    led_reset: assert property (@(posedge clk) rst |=> led == '0)
        else $error("led not cleared by reset");

endmodule

bind udp_echo_top udp_echo_assertions u_assertions (.*);

// ==== dv/udp_echo_tb.sv ====
// Testbench for the UDP echo core, pattern driven with random tx back-pressure
`timescale 1ns/1ps

module udp_echo_tb;

    localparam int MAX_FRAMES     = 32;
    localparam int TIMEOUT_CYCLES = 2000;
    // Pattern line whose last beat carries the error flag
    localparam int USER_ERR_FRAME = 2;
    localparam udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234;
    localparam udp_echo_pkg::ip_addr_t  LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};

    logic                        clk;
    logic                        rst;
    udp_echo_pkg::udp_hdr_t      rx_hdr;
    logic                        rx_hdr_valid;
    logic                        rx_hdr_ready;
    udp_echo_pkg::payload_beat_t rx_payload;
    logic                        rx_payload_valid;
    logic                        rx_payload_ready;
    udp_echo_pkg::udp_hdr_t      tx_hdr;
    logic                        tx_hdr_valid;
    logic                        tx_hdr_ready;
    udp_echo_pkg::payload_beat_t tx_payload;
    logic                        tx_payload_valid;
    logic                        tx_payload_ready;
    udp_echo_pkg::led_t          led;

    udp_echo_pkg::udp_hdr_t        frame_hdr  [MAX_FRAMES];
    int                            frame_beats[MAX_FRAMES];
    udp_echo_pkg::payload_data_t   frame_word [MAX_FRAMES];
    int                            num_frames;

    udp_echo_pkg::udp_hdr_t        exp_hdr_q[$];
    udp_echo_pkg::payload_beat_t   exp_beat_q[$];
    udp_echo_pkg::led_t            exp_led_q[$];

    int     errors;
    int     tests_passed;
    int     tests_failed;
    bit     bp_en;
    integer seed;
    bit     mon_in_frame;
    bit     led_pending;
    udp_echo_pkg::led_t led_want;
    udp_echo_pkg::led_t cur_led;

    udp_echo_top UUT (.*);

    always #5 clk = ~clk;

    // Random ready on both tx streams while back-pressure is on
    always begin
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = $random(seed);
        tx_hdr_ready     = bp_en ? r[0] : 1'b1;
        tx_payload_ready = bp_en ? r[5] : 1'b1;
    end

    function automatic udp_echo_pkg::payload_beat_t make_beat(int f, int i);
        udp_echo_pkg::payload_beat_t b;
        b.data = frame_word[f] + 64'(i);
        b.last = (i == frame_beats[f] - 1);
        b.keep = b.last ? 8'h0f : 8'hff;
        b.user = b.last && (f == USER_ERR_FRAME);
        return b;
    endfunction

    function automatic udp_echo_pkg::udp_hdr_t make_reply(udp_echo_pkg::udp_hdr_t h);
        udp_echo_pkg::udp_hdr_t r;
        r.source_ip   = LOCAL_IP;
        r.dest_ip     = h.source_ip;
        r.source_port = h.dest_port;
        r.dest_port   = h.source_port;
        r.length      = h.length;
        return r;
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        int          nb;
        string       line;
        logic [31:0] sip;
        logic [31:0] dip;
        logic [15:0] sp;
        logic [15:0] dp;
        logic [15:0] len;
        logic [63:0] w;
        num_frames = 0;
        fd = $fopen("dv/udp_echo_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file dv/udp_echo_patterns.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_frames < MAX_FRAMES) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %d %h", sip, dip, sp, dp, len, nb, w);
                if (n == 7) begin
                    frame_hdr[num_frames]   = '{sip, dip, sp, dp, len};
                    frame_beats[num_frames] = nb;
                    frame_word[num_frames]  = w;
                    num_frames++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Only frames for the echo port leave anything on the tx side
    task automatic queue_expected();
        for (int f = 0; f < num_frames; f++) begin
            if (frame_hdr[f].dest_port == ECHO_PORT) begin
                exp_hdr_q.push_back(make_reply(frame_hdr[f]));
                exp_led_q.push_back(frame_word[f][7:0]);
                for (int i = 0; i < frame_beats[f]; i++) begin
                    exp_beat_q.push_back(make_beat(f, i));
                end
            end
        end
    endtask

    task automatic send_headers();
        int n;
        bit got;
        for (int f = 0; f < num_frames; f++) begin
            rx_hdr       = frame_hdr[f];
            rx_hdr_valid = 1'b1;
            got = 1'b0;
            n   = 0;
            while (!got && n < TIMEOUT_CYCLES) begin
                @(posedge clk);
                got = rx_hdr_ready;
                n++;
            end
            #1;
            if (!got) begin
                $display("Timeout: header of frame %0d was never accepted", f);
                errors++;
                rx_hdr_valid = 1'b0;
                return;
            end
        end
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_payload();
        int n;
        bit got;
        for (int f = 0; f < num_frames; f++) begin
            for (int i = 0; i < frame_beats[f]; i++) begin
                rx_payload       = make_beat(f, i);
                rx_payload_valid = 1'b1;
                got = 1'b0;
                n   = 0;
                while (!got && n < TIMEOUT_CYCLES) begin
                    @(posedge clk);
                    got = rx_payload_ready;
                    n++;
                end
                #1;
                if (!got) begin
                    $display("Timeout: beat %0d of frame %0d was never accepted", i, f);
                    errors++;
                    rx_payload_valid = 1'b0;
                    return;
                end
            end
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            $display("Timeout: tx side still owes %0d headers and %0d beats",
                     exp_hdr_q.size(), exp_beat_q.size());
            errors++;
            exp_hdr_q.delete();
            exp_beat_q.delete();
        end
        // Idle cycles so stray outputs and the last LED update get seen
        repeat (10) @(posedge clk);
    endtask

    task automatic run_echo_test(string name, bit backpressure);
        int err_before;
        err_before = errors;
        @(posedge clk);
        // Set on the edge so the ready generator sees it one step later
        bp_en = backpressure;
        #1;
        queue_expected();
        fork
            send_headers();
            send_payload();
        join
        wait_drained();
        bp_en = 1'b0;
        if (errors == err_before) begin
            tests_passed++;
            $display("Test %s finished: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s finished: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // Scoreboard on the tx side
    always @(posedge clk) begin
        if (!rst) begin
            if (led_pending) begin
                if (led !== led_want) begin
                    $display("ERROR %0t: led %h, expected %h", $time, led, led_want);
                    errors++;
                end
                led_pending = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    $display("ERROR %0t: unexpected reply header %h", $time, tx_hdr);
                    errors++;
                end else if (tx_hdr !== exp_hdr_q[0]) begin
                    $display("ERROR %0t: reply header %h, expected %h",
                             $time, tx_hdr, exp_hdr_q[0]);
                    errors++;
                    void'(exp_hdr_q.pop_front());
                end else begin
                    void'(exp_hdr_q.pop_front());
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (!mon_in_frame && exp_led_q.size() != 0) begin
                    cur_led = exp_led_q.pop_front();
                end
                if (tx_payload.last) begin
                    led_pending = 1'b1;
                    led_want    = cur_led;
                end
                mon_in_frame = !tx_payload.last;
                if (exp_beat_q.size() == 0) begin
                    $display("ERROR %0t: unexpected payload beat %h", $time, tx_payload);
                    errors++;
                end else if (tx_payload !== exp_beat_q[0]) begin
                    $display("ERROR %0t: payload beat %h, expected %h",
                             $time, tx_payload, exp_beat_q[0]);
                    errors++;
                    void'(exp_beat_q.pop_front());
                end else begin
                    void'(exp_beat_q.pop_front());
                end
            end
        end
    end

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        rx_hdr           = '0;
        rx_hdr_valid     = 1'b0;
        rx_payload       = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        seed             = 32'he06f_38ae;
        errors           = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        bp_en            = 1'b0;
        mon_in_frame     = 1'b0;
        led_pending      = 1'b0;
        led_want         = '0;
        cur_led          = '0;

        load_patterns();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        @(posedge clk);
        if (led !== 8'h00 || tx_hdr_valid !== 1'b0 || tx_payload_valid !== 1'b0) begin
            $display("ERROR %0t: after reset led %h, tx valids %b %b",
                     $time, led, tx_hdr_valid, tx_payload_valid);
            errors++;
            tests_failed++;
            $display("Test reset_state finished: failed");
        end else begin
            tests_passed++;
            $display("Test reset_state finished: passed");
        end

        run_echo_test("echo_full_rate", 1'b0);
        run_echo_test("echo_random_backpressure", 1'b1);
        run_echo_test("echo_repeat_backpressure", 1'b1);

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== dv/udp_echo_patterns.txt ====
# Columns: source_ip dest_ip source_port dest_port length (hex), beats (decimal), first_word (hex)
# Port 04d2 (1234) is echoed, any other port is dropped
c0a80105 c0a80180 9c40 04d2 0020 3 1111222233334400
c0a80106 c0a80180 9c41 0050 0018 2 aaaa5555aaaa5510
c0a8010a c0a80180 1f90 04d2 0010 1 0123456789abcd20
0a000001 c0a80180 d431 04d2 0040 6 fedcba9876543230
0a000002 c0a80180 d432 04d3 0028 4 5a5a5a5a5a5a5a40
0a000003 c0a80180 d433 04d1 0010 1 0000000000000050
ac100001 c0a80180 0035 04d2 0030 5 cafef00ddeadbe60
ac100002 c0a80180 0036 04d2 0018 2 0000000100000270
c0a80107 c0a80180 c350 1234 0038 7 1234123412341280
c0a80108 c0a80180 c351 04d2 0048 8 9999888877776690
c0a80109 c0a80180 c352 0000 0010 1 abababababababa0
c0a8010b c0a80180 04d2 04d2 0020 3 13579bdf02468ab0
08080808 c0a80180 ffff 04d2 0010 1 00000000000000c0
08080404 c0a80180 0001 ffff 0020 3 77777777777777d0
c0a8010c c0a80180 8000 04d2 0060 12 0f0f0f0f0f0f0fe0
c0a8010d c0a80180 8001 04d2 0018 2 f0f0f0f0f0f0f0f0

// ==== filelist.f ====
rtl/udp_echo_pkg.sv
rtl/udp_port_filter.sv
rtl/udp_reply_header.sv
rtl/udp_payload_fifo.sv
rtl/payload_led_latch.sv
rtl/udp_echo_top.sv
dv/udp_echo_assertions.sv
dv/udp_echo_tb.sv

// ==== Makefile ====
# Verilator build and run for the UDP echo core

SIM_TOP   ?= udp_echo_tb
SEED      ?= 1
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: SIM_TOP SEED LOG VERILATOR BUILD_DIR"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
